// ==== src/wiscDecode_settings.svh ====
`ifndef WISC_DECODE_SETTINGS_SVH
`define WISC_DECODE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////////////////////////

// Datapath and address width
`define WISC_DATA_W 16

// Architectural register count
`define WISC_REG_COUNT 16

// Register ID width, enough for WISC_REG_COUNT entries
`define WISC_REG_ID_W 4

`endif

// ==== src/wiscDecodePkg.sv ====
`include "wiscDecode_settings.svh"

package wiscDecodePkg;

  typedef logic [`WISC_DATA_W-1:0]   data_t;   // Datapath word / PC
  typedef logic [`WISC_REG_ID_W-1:0] regId_t;  // Register ID

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Opcode field instr[15:12]
  typedef enum logic [3:0] {
    opAdd    = 4'h0,
    opSub    = 4'h1,
    opXor    = 4'h2,
    opRed    = 4'h3,
    opSll    = 4'h4,
    opSra    = 4'h5,
    opRor    = 4'h6,
    opPaddsb = 4'h7,
    opLw     = 4'h8,
    opSw     = 4'h9,
    opLlb    = 4'hA,
    opLhb    = 4'hB,
    opB      = 4'hC,
    opBr     = 4'hD,
    opPcs    = 4'hE,
    opHlt    = 4'hF
  } opcode_e;

  // Branch condition field instr[11:9]
  typedef enum logic [2:0] {
    condNe = 3'b000,  // Z=0
    condEq = 3'b001,  // Z=1
    condGt = 3'b010,  // Z=0 and N=0
    condLt = 3'b011,  // N=1
    condGe = 3'b100,  // Z=1 or N=0
    condLe = 3'b101,  // Z=1 or N=1
    condOv = 3'b110,  // V=1
    condUn = 3'b111   // Unconditional
  } cond_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic zf;
    logic vf;
    logic nf;
  } flags_t;

  // IF/ID register contents
  typedef struct packed {
    data_t pcCurr;           // PC of this instruction
    data_t instr;            // Instruction word
    data_t pcNext;           // Sequential next PC
    logic  predictedTaken;   // BHT prediction
    data_t predictedTarget;  // BTB prediction
  } fetchBundle_t;

  // Control unit outputs
  typedef struct packed {
    logic    branch;
    opcode_e aluOp;
    logic    aluSrc;     // Immediate operand
    logic    regSrc;     // LLB/LHB read rd
    logic    zEn;
    logic    nvEn;
    logic    memEnable;
    logic    memWrite;
    logic    regWrite;
    logic    memToReg;
    logic    hlt;
    logic    pcs;
  } ctrlSignals_t;

  // Execute stage bundle, 63 bits
  typedef struct packed {
    regId_t  srcReg1;
    regId_t  srcReg2;
    data_t   aluIn1;
    data_t   aluImm;
    data_t   aluIn2;
    opcode_e aluOp;
    logic    aluSrc;
    logic    zEn;
    logic    nvEn;
  } exCtrl_t;

  // Memory stage bundle, 18 bits
  typedef struct packed {
    data_t memWriteData;
    logic  memEnable;
    logic  memWrite;
  } memCtrl_t;

  // Write-back stage bundle, 8 bits
  typedef struct packed {
    regId_t rd;
    logic   regWrite;
    logic   memToReg;
    logic   hlt;
    logic   pcs;
  } wbCtrl_t;

  // Register file write port from MEM/WB
  typedef struct packed {
    logic   we;
    regId_t rd;
    data_t  data;
  } regWrite_t;

  // Branch resolution toward fetch and predictor
  typedef struct packed {
    logic  isBranch;
    logic  isBr;          // Register target form
    logic  taken;
    logic  wenBht;
    logic  wenBtb;
    data_t branchTarget;  // Computed target
    data_t actualTarget;  // Target or fall-through
    logic  updatePc;      // Redirect fetch
  } branchResult_t;

endpackage

// ==== src/controlUnit.sv ====
module controlUnit (
  input  wiscDecodePkg::opcode_e      opcode,
  output wiscDecodePkg::ctrlSignals_t ctrl
);

  //////////////////////////////////////////////////////////////////////
  // Opcode decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl       = '0;        // All inactive unless decoded below
    ctrl.aluOp = opcode;    // ALU op follows opcode by default

    case (opcode)
      wiscDecodePkg::opAdd,
      wiscDecodePkg::opSub: begin
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1;   // Arithmetic sets N and V
        ctrl.regWrite = 1'b1;
      end

      wiscDecodePkg::opXor: begin
        ctrl.zEn      = 1'b1;
        ctrl.regWrite = 1'b1;
      end

      wiscDecodePkg::opRed,
      wiscDecodePkg::opPaddsb: begin
        ctrl.regWrite = 1'b1;   // No flag update
      end

      // Shifts and rotate take the 4-bit immediate
      wiscDecodePkg::opSll,
      wiscDecodePkg::opSra,
      wiscDecodePkg::opRor: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.zEn      = 1'b1;
        ctrl.regWrite = 1'b1;
      end

      wiscDecodePkg::opLw: begin
        ctrl.aluOp     = wiscDecodePkg::opAdd;  // Address = base + offset
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memToReg  = 1'b1;
      end

      wiscDecodePkg::opSw: begin
        ctrl.aluOp     = wiscDecodePkg::opAdd;
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
      end

      // Byte loads read rd back as the merge source
      wiscDecodePkg::opLlb,
      wiscDecodePkg::opLhb: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end

      wiscDecodePkg::opB,
      wiscDecodePkg::opBr: begin
        ctrl.branch = 1'b1;
      end

      wiscDecodePkg::opPcs: begin
        ctrl.regWrite = 1'b1;   // rd gets PC + 2
        ctrl.pcs      = 1'b1;
      end

      wiscDecodePkg::opHlt: begin
        ctrl.hlt = 1'b1;
      end

      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== src/branchControl.sv ====
module branchControl (
  input  wiscDecodePkg::cond_e         cond,             // instr[11:9]
  input  logic [8:0]                   offset,           // instr[8:0], word offset
  input  wiscDecodePkg::flags_t        flags,
  input  wiscDecodePkg::data_t         rsData,           // BR target source
  input  logic                         branch,           // B or BR
  input  logic                         isBr,             // instr[12]
  input  wiscDecodePkg::data_t         pcNext,
  input  logic                         predictedTaken,
  input  wiscDecodePkg::data_t         predictedTarget,
  output wiscDecodePkg::branchResult_t result
);

  logic                 condMet;     // Condition holds on current flags
  wiscDecodePkg::data_t offsetExt;   // Byte offset, sign extended
  wiscDecodePkg::data_t target;
  logic                 taken;

  //////////////////////////////////////////////////////////////////////
  // Condition evaluation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cond)
      wiscDecodePkg::condNe: condMet = ~flags.zf;
      wiscDecodePkg::condEq: condMet = flags.zf;
      wiscDecodePkg::condGt: condMet = ~flags.zf & ~flags.nf;
      wiscDecodePkg::condLt: condMet = flags.nf;
      wiscDecodePkg::condGe: condMet = flags.zf | ~flags.nf;
      wiscDecodePkg::condLe: condMet = flags.zf | flags.nf;
      wiscDecodePkg::condOv: condMet = flags.vf;
      wiscDecodePkg::condUn: condMet = 1'b1;
      default:               condMet = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Target selection
  //////////////////////////////////////////////////////////////////////

  // Offset counts halfwords so shift left by one
  assign offsetExt = {{($bits(wiscDecodePkg::data_t) - 10){offset[8]}}, offset, 1'b0};

  assign target = isBr ? rsData : (pcNext + offsetExt);  // Register or PC-relative

  assign taken = branch & condMet;

  always_comb begin
    result              = '0;
    result.isBranch     = branch;
    result.isBr         = isBr;
    result.taken        = taken;
    result.branchTarget = target;
    result.actualTarget = taken ? target : pcNext;  // Fall through when not taken
    result.wenBht       = branch;                   // Train BHT on every branch
    // BTB learns on a taken branch it missed or mistargeted
    result.wenBtb       = taken & (~predictedTaken | (predictedTarget != target));
    result.updatePc     = 1'b0;                     // Filled in by decode
  end

endmodule

// ==== src/registerFile.sv ====
`include "wiscDecode_settings.svh"

module registerFile (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic [`WISC_REG_ID_W-1:0]   rdAddr1,
  input  logic [`WISC_REG_ID_W-1:0]   rdAddr2,
  input  wiscDecodePkg::regWrite_t    wbWrite,   // From MEM/WB
  output logic [`WISC_DATA_W-1:0]     rdData1,
  output logic [`WISC_DATA_W-1:0]     rdData2
);

  logic [`WISC_DATA_W-1:0] regs [`WISC_REG_COUNT];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `WISC_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite.we && (wbWrite.rd != '0)) begin  // R0 never written
      regs[wbWrite.rd] <= wbWrite.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // R0 reads zero, in-flight write bypasses the array
  function automatic logic [`WISC_DATA_W-1:0] readReg(input logic [`WISC_REG_ID_W-1:0] addr);
    if (addr == '0)
      return '0;
    else if (wbWrite.we && (wbWrite.rd == addr))
      return wbWrite.data;
    else
      return regs[addr];
  endfunction

  assign rdData1 = readReg(rdAddr1);
  assign rdData2 = readReg(rdAddr2);

endmodule

// ==== src/decode.sv ====
module decode (
  input  logic                          clk,
  input  logic                          arstN,
  input  wiscDecodePkg::fetchBundle_t   fetch,      // IF/ID contents
  input  wiscDecodePkg::flags_t         flags,
  input  wiscDecodePkg::regWrite_t      wbWrite,    // Register file write from MEM/WB
  output wiscDecodePkg::exCtrl_t        exNext,
  output wiscDecodePkg::memCtrl_t       memNext,
  output wiscDecodePkg::wbCtrl_t        wbNext,
  output wiscDecodePkg::branchResult_t  branchOut
);

  wiscDecodePkg::opcode_e        opcode;
  wiscDecodePkg::ctrlSignals_t   ctrl;
  wiscDecodePkg::branchResult_t  bcResult;     // Before updatePc
  logic                          isNop;
  wiscDecodePkg::regId_t         rd;
  wiscDecodePkg::regId_t         rs;
  wiscDecodePkg::regId_t         rt;
  wiscDecodePkg::regId_t         srcReg1;
  wiscDecodePkg::regId_t         srcReg2;
  wiscDecodePkg::data_t          srcData1;
  wiscDecodePkg::data_t          srcData2;
  wiscDecodePkg::data_t          aluImm;

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////

  assign opcode = wiscDecodePkg::opcode_e'(fetch.instr[15:12]);
  assign isNop  = (fetch.instr == '0);  // Whole word zero

  assign rd = fetch.instr[11:8];
  assign rs = fetch.instr[7:4];
  assign rt = fetch.instr[3:0];

  controlUnit uControl (
    .opcode (opcode),
    .ctrl   (ctrl)
  );

  // LLB/LHB merge into rd, SW stores rd
  assign srcReg1 = ctrl.regSrc   ? rd : rs;
  assign srcReg2 = ctrl.memWrite ? rd : rt;

  registerFile uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddr1 (srcReg1),
    .rdAddr2 (srcReg2),
    .wbWrite (wbWrite),
    .rdData1 (srcData1),
    .rdData2 (srcData2)
  );

  // 8-bit byte immediate, signed memory offset, else unsigned shift amount
  assign aluImm = ctrl.regSrc    ? {8'h00, fetch.instr[7:0]} :
                  ctrl.memEnable ? {{12{fetch.instr[3]}}, fetch.instr[3:0]} :
                                   {12'h000, fetch.instr[3:0]};

  //////////////////////////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////////////////////////

  branchControl uBranch (
    .cond            (wiscDecodePkg::cond_e'(fetch.instr[11:9])),
    .offset          (fetch.instr[8:0]),
    .flags           (flags),
    .rsData          (srcData1),          // rs read, regSrc low on branches
    .branch          (ctrl.branch),
    .isBr            (fetch.instr[12]),
    .pcNext          (fetch.pcNext),
    .predictedTaken  (fetch.predictedTaken),
    .predictedTarget (fetch.predictedTarget),
    .result          (bcResult)
  );

  always_comb begin
    branchOut          = bcResult;
    // Redirect when the fetched path is not the resolved one
    branchOut.updatePc = ctrl.branch & (fetch.pcCurr != bcResult.actualTarget);
  end

  //////////////////////////////////////////////////////////////////////
  // Stage bundles
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    exNext  = '0;
    memNext = '0;
    wbNext  = '0;
    if (!isNop) begin
      exNext.srcReg1       = srcReg1;
      exNext.srcReg2       = srcReg2;
      exNext.aluIn1        = srcData1;
      exNext.aluImm        = aluImm;
      exNext.aluIn2        = srcData2;   // EX picks imm via aluSrc
      exNext.aluOp         = ctrl.aluOp;
      exNext.aluSrc        = ctrl.aluSrc;
      exNext.zEn           = ctrl.zEn;
      exNext.nvEn          = ctrl.nvEn;
      memNext.memWriteData = srcData2;   // SW data from rd
      memNext.memEnable    = ctrl.memEnable;
      memNext.memWrite     = ctrl.memWrite;
      wbNext.rd            = rd;
      wbNext.regWrite      = ctrl.regWrite;
      wbNext.memToReg      = ctrl.memToReg;
      wbNext.hlt           = ctrl.hlt;
      wbNext.pcs           = ctrl.pcs;
    end
  end

endmodule

// ==== src/stageRegister.sv ====
module stageRegister #(
  parameter type payload_t = logic [7:0]  // Stage bundle type
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     stall,   // Hold current contents
  input  logic     flush,   // Insert bubble, wins over stall
  input  payload_t d,
  output payload_t q
);

  //////////////////////////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;              // All-zero bundle is a bubble
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== src/wiscDecodeTop.sv ====
module wiscDecodeTop (
  input  logic                          clk,
  input  logic                          arstN,
  input  wiscDecodePkg::fetchBundle_t   fetch,      // Held by IF under stall
  input  wiscDecodePkg::flags_t         flags,
  input  wiscDecodePkg::regWrite_t      wbWrite,
  input  logic                          stall,
  input  logic                          flush,
  output wiscDecodePkg::exCtrl_t        exOut,      // ID/EX registered
  output wiscDecodePkg::memCtrl_t       memOut,
  output wiscDecodePkg::wbCtrl_t        wbOut,
  output wiscDecodePkg::branchResult_t  branchOut   // Same cycle as fetch
);

  wiscDecodePkg::exCtrl_t  exNext;
  wiscDecodePkg::memCtrl_t memNext;
  wiscDecodePkg::wbCtrl_t  wbNext;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  decode uDecode (
    .clk       (clk),
    .arstN     (arstN),
    .fetch     (fetch),
    .flags     (flags),
    .wbWrite   (wbWrite),
    .exNext    (exNext),
    .memNext   (memNext),
    .wbNext    (wbNext),
    .branchOut (branchOut)
  );

  //////////////////////////////////////////////////////////////////////
  // ID/EX registers
  //////////////////////////////////////////////////////////////////////

  stageRegister #(.payload_t(wiscDecodePkg::exCtrl_t)) uExReg (
    .clk   (clk),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .d     (exNext),
    .q     (exOut)
  );

  stageRegister #(.payload_t(wiscDecodePkg::memCtrl_t)) uMemReg (
    .clk   (clk),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .d     (memNext),
    .q     (memOut)
  );

  stageRegister #(.payload_t(wiscDecodePkg::wbCtrl_t)) uWbReg (
    .clk   (clk),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .d     (wbNext),
    .q     (wbOut)
  );

endmodule

// ==== test/wiscDecodeTb.sv ====
`include "wiscDecode_settings.svh"

module wiscDecodeTb;

  localparam int ClkPeriod    = 100;
  localparam int DriveDelay   = 10;                         // Input skew after rising edge
  localparam int TestCycles   = 700;                        // Upper bound on test length
  localparam int WatchdogTime = 2 * TestCycles * ClkPeriod;

  logic                         clk;
  logic                         arstN;
  wiscDecodePkg::fetchBundle_t  fetch;
  wiscDecodePkg::flags_t        flags;
  wiscDecodePkg::regWrite_t     wbWrite;
  logic                         stall;
  logic                         flush;
  wiscDecodePkg::exCtrl_t       exOut;
  wiscDecodePkg::memCtrl_t      memOut;
  wiscDecodePkg::wbCtrl_t       wbOut;
  wiscDecodePkg::branchResult_t branchOut;

  integer seed = 64;
  string  testName = "init";

  logic [`WISC_DATA_W-1:0] shadow [`WISC_REG_COUNT];  // Architectural register model

  // Expected next and registered bundles
  wiscDecodePkg::exCtrl_t       expExNext, expEx;
  wiscDecodePkg::memCtrl_t      expMemNext, expMem;
  wiscDecodePkg::wbCtrl_t       expWbNext, expWb;
  wiscDecodePkg::branchResult_t expBranch, branchView;

  logic [3:0]  op, rdId, rsId, rtId;
  logic        isMem, isByte, isBranchOp, taken;
  logic [15:0] rsVal, offsetBytes, target;

  wiscDecodeTop u_wiscDecodeTop (
    .clk       (clk),
    .arstN     (arstN),
    .fetch     (fetch),
    .flags     (flags),
    .wbWrite   (wbWrite),
    .stall     (stall),
    .flush     (flush),
    .exOut     (exOut),
    .memOut    (memOut),
    .wbOut     (wbOut),
    .branchOut (branchOut)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // R0 is zero, a write in the same cycle is seen at once
  function automatic logic [15:0] readShadow(input logic [3:0] id);
    if (id == 4'h0)
      return 16'h0000;
    if (wbWrite.we && (wbWrite.rd == id))
      return wbWrite.data;
    return shadow[id];
  endfunction

  function automatic logic condHolds(input logic [2:0] cond, input wiscDecodePkg::flags_t f);
    case (cond)
      3'b000:  return !f.zf;             // NE
      3'b001:  return f.zf;              // EQ
      3'b010:  return !f.zf && !f.nf;    // GT
      3'b011:  return f.nf;              // LT
      3'b100:  return f.zf || !f.nf;     // GE
      3'b101:  return f.zf || f.nf;      // LE
      3'b110:  return f.vf;              // OV
      default: return 1'b1;              // UN
    endcase
  endfunction

  always_comb begin
    op         = fetch.instr[15:12];
    rdId       = fetch.instr[11:8];
    rsId       = fetch.instr[7:4];
    rtId       = fetch.instr[3:0];
    isMem      = (op == 4'h8) || (op == 4'h9);
    isByte     = (op == 4'hA) || (op == 4'hB);
    expExNext  = '0;
    expMemNext = '0;
    expWbNext  = '0;
    if (fetch.instr != 16'h0000) begin  // Zero word is the NOP
      expExNext.srcReg1 = isByte ? rdId : rsId;
      expExNext.srcReg2 = (op == 4'h9) ? rdId : rtId;
      expExNext.aluIn1  = readShadow(expExNext.srcReg1);
      expExNext.aluIn2  = readShadow(expExNext.srcReg2);
      if (isByte)
        expExNext.aluImm = {8'h00, fetch.instr[7:0]};
      else if (isMem)
        expExNext.aluImm = {{12{fetch.instr[3]}}, fetch.instr[3:0]};
      else
        expExNext.aluImm = {12'h000, fetch.instr[3:0]};
      expExNext.aluOp  = wiscDecodePkg::opcode_e'(isMem ? 4'h0 : op);  // Address add
      expExNext.aluSrc = op inside {4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hA, 4'hB};
      expExNext.zEn    = op inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6};
      expExNext.nvEn   = (op == 4'h0) || (op == 4'h1);
      expMemNext.memWriteData = expExNext.aluIn2;
      expMemNext.memEnable    = isMem;
      expMemNext.memWrite     = (op == 4'h9);
      expWbNext.rd       = rdId;
      expWbNext.regWrite = (op <= 4'h8) || isByte || (op == 4'hE);
      expWbNext.memToReg = (op == 4'h8);
      expWbNext.hlt      = (op == 4'hF);
      expWbNext.pcs      = (op == 4'hE);
    end
  end

  always_comb begin
    isBranchOp  = (op == 4'hC) || (op == 4'hD);
    rsVal       = readShadow(rsId);
    offsetBytes = {{6{fetch.instr[8]}}, fetch.instr[8:0], 1'b0};  // Halfword offset
    target      = fetch.instr[12] ? rsVal : fetch.pcNext + offsetBytes;
    taken       = isBranchOp && condHolds(fetch.instr[11:9], flags);
    expBranch              = '0;
    expBranch.isBranch     = isBranchOp;
    expBranch.isBr         = fetch.instr[12];
    expBranch.taken        = taken;
    expBranch.wenBht       = isBranchOp;
    expBranch.wenBtb       = taken && (!fetch.predictedTaken || fetch.predictedTarget != target);
    expBranch.branchTarget = isBranchOp ? target : 16'h0000;
    expBranch.actualTarget = taken ? target : fetch.pcNext;
    expBranch.updatePc     = isBranchOp && (fetch.pcCurr != expBranch.actualTarget);
    branchView = branchOut;
    if (!isBranchOp)
      branchView.branchTarget = 16'h0000;  // Target only defined for B and BR
  end

  // Registered view and register contents
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      expEx  <= '0;
      expMem <= '0;
      expWb  <= '0;
      for (int i = 0; i < `WISC_REG_COUNT; i++)
        shadow[i] <= '0;
    end else begin
      if (flush) begin  // Bubble even under stall
        expEx  <= '0;
        expMem <= '0;
        expWb  <= '0;
      end else if (!stall) begin
        expEx  <= expExNext;
        expMem <= expMemNext;
        expWb  <= expWbNext;
      end
      if (wbWrite.we && (wbWrite.rd != 4'h0))
        shadow[wbWrite.rd] <= wbWrite.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string field, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    $display("FAIL %s/%s expected %h actual %h", testName, field, expVal, actVal);
    $display("Simulation finished: FAIL");
    $fatal(1, "Output mismatch");
  endtask

  // Sampled mid-cycle, away from both edges
  exCheck: assert property (@(negedge clk) exOut == expEx)
    else reportMismatch("exOut", 64'(expEx), 64'(exOut));
  memCheck: assert property (@(negedge clk) memOut == expMem)
    else reportMismatch("memOut", 64'(expMem), 64'(memOut));
  wbCheck: assert property (@(negedge clk) wbOut == expWb)
    else reportMismatch("wbOut", 64'(expWb), 64'(wbOut));
  branchCheck: assert property (@(negedge clk) branchView == expBranch)
    else reportMismatch("branchOut", 64'(expBranch), 64'(branchView));

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic nextCycle();
    @(posedge clk);
    #(DriveDelay);
  endtask

  // Drives one fetch, aligned lines up prediction and pcCurr with a B target
  task automatic issue(input logic [15:0] instr, input logic aligned);
    logic [15:0] offs;
    offs                  = {{6{instr[8]}}, instr[8:0], 1'b0};
    fetch.instr           = instr;
    fetch.pcNext          = 16'($random(seed));
    fetch.pcCurr          = fetch.pcNext - 16'd2;
    fetch.predictedTaken  = 1'($random(seed));
    fetch.predictedTarget = 16'($random(seed));
    flags                 = 3'($random(seed));
    if (aligned) begin
      fetch.predictedTaken  = 1'b1;
      fetch.predictedTarget = fetch.pcNext + offs;
      fetch.pcCurr          = fetch.predictedTarget;
    end
    nextCycle();
  endtask

  task automatic setWrite(input logic we, input logic [3:0] rd, input logic [15:0] data);
    wbWrite.we   = we;
    wbWrite.rd   = rd;
    wbWrite.data = data;
  endtask

  function automatic logic [3:0] pickRegOp(input logic [2:0] sel);
    case (sel)
      3'd0, 3'd5: return 4'h0;  // ADD
      3'd1, 3'd6: return 4'h1;  // SUB
      3'd2:       return 4'h2;  // XOR
      3'd3:       return 4'h8;  // LW
      default:    return 4'h9;  // SW
    endcase
  endfunction

  function automatic logic [3:0] pickImmOp(input logic [2:0] sel);
    case (sel)
      3'd0:    return 4'h4;  // SLL
      3'd1:    return 4'h5;  // SRA
      3'd2:    return 4'h6;  // ROR
      3'd3:    return 4'h9;  // SW
      3'd4:    return 4'hA;  // LLB
      3'd5:    return 4'hB;  // LHB
      default: return 4'h8;  // LW
    endcase
  endfunction

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogTime);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    logic [15:0] rnd;
    arstN = 1'b0;
    fetch = '0;
    fetch.instr = 16'h1234;  // Live instruction while in reset
    flags = '0;
    wbWrite = '0;
    stall = 1'b0;
    flush = 1'b0;

    testName = "reset";
    repeat (4) @(posedge clk);
    #(DriveDelay);
    arstN = 1'b1;
    issue(16'h0000, 1'b0);

    testName = "regFill";
    for (int r = 1; r < `WISC_REG_COUNT; r++) begin
      setWrite(1'b1, 4'(r), 16'($random(seed)));
      issue({4'h0, 4'h1, 4'(r), 4'(r)}, 1'b0);  // Reads the register being written
    end

    testName = "rType";
    for (int n = 0; n < 40; n++) begin
      rnd = 16'($random(seed));
      setWrite(1'($random(seed)), 4'($random(seed)), 16'($random(seed)));
      issue({pickRegOp(3'($random(seed))), rnd[11:0]}, 1'b0);
    end
    setWrite(1'b0, 4'h0, 16'h0000);

    testName = "immediate";
    issue({4'h8, 4'h2, 4'h3, 4'hC}, 1'b0);  // LW negative offset
    issue({4'h9, 4'h4, 4'h5, 4'h3}, 1'b0);  // SW positive offset
    for (int n = 0; n < 30; n++) begin
      rnd = 16'($random(seed));
      issue({pickImmOp(3'($random(seed))), rnd[11:0]}, 1'b0);
    end

    testName = "branch";
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 8; k++) begin
        rnd = 16'($random(seed));
        issue({(k[0] ? 4'hD : 4'hC), 3'(c), rnd[8:0]}, k[1]);
      end
    end

    testName = "regCorner";
    setWrite(1'b1, 4'h0, 16'hFFFF);          // R0 write is dropped
    issue({4'h0, 4'h1, 4'h0, 4'h0}, 1'b0);
    setWrite(1'b0, 4'h0, 16'h0000);
    issue({4'h1, 4'h2, 4'h0, 4'h0}, 1'b0);
    setWrite(1'b1, 4'h5, 16'($random(seed)));  // Bypass of fresh data
    issue({4'h2, 4'h6, 4'h5, 4'h5}, 1'b0);
    setWrite(1'b0, 4'h0, 16'h0000);

    testName = "pipeline";
    issue(16'h0000, 1'b0);
    issue({4'h0, 4'h3, 4'h4, 4'h5}, 1'b0);
    stall = 1'b1;                             // Fetch held upstream
    setWrite(1'b1, 4'h4, 16'($random(seed)));
    repeat (3) nextCycle();
    setWrite(1'b0, 4'h0, 16'h0000);
    flush = 1'b1;                             // Flush while still stalled
    nextCycle();
    stall = 1'b0;
    issue({4'h1, 4'h7, 4'h8, 4'h9}, 1'b0);
    flush = 1'b0;
    issue(16'hF000, 1'b0);                    // HLT
    issue(16'hE300, 1'b0);                    // PCS
    issue(16'h0000, 1'b0);
    repeat (2) nextCycle();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== wiscDecode.f ====
+incdir+src
src/wiscDecodePkg.sv
src/controlUnit.sv
src/branchControl.sv
src/registerFile.sv
src/decode.sv
src/stageRegister.sv
src/wiscDecodeTop.sv
test/wiscDecodeTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the wiscDecode testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f wiscDecode.f \
  --top-module wiscDecodeTb -o wiscDecodeSim \
  && ./obj_dir/wiscDecodeSim > sim.log 2>&1 \
  || echo "Build or simulation returned an error" >> sim.log

cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
